/* design/parser_pkg.sv */
`default_nettype none

package parser_pkg;

    localparam int DATA_WIDTH  = 512;
    localparam int HDR_BYTES   = 128;
    localparam int NUM_ACTIONS = 10;
    localparam int TABLE_DEPTH = 16;
    // vlan id position inside the first beat
    localparam int VLAN_LSB    = 116;

    // byte k at bits 8k+7:8k, first beat in bytes 0..63
    typedef logic [HDR_BYTES*8-1:0] hdr_t;

    typedef enum logic [1:0] {
        CT_NONE,
        CT_2B,
        CT_4B,
        CT_6B
    } ctype_e;

    typedef struct packed {
        logic [3:0] rsvd;
        ctype_e     kind;
        logic [2:0] idx;
        logic [6:0] offset;
    } parse_action_t;

    // action 0 sits in the top 16 bits
    typedef parse_action_t [0:NUM_ACTIONS-1] table_entry_t;

    typedef struct packed {
        ctype_e      kind;
        logic [2:0]  idx;
        logic [47:0] value;
    } field_t;

    typedef struct packed {
        logic [7:0][47:0] c6;
        logic [7:0][31:0] c4;
        logic [7:0][15:0] c2;
        logic [11:0]      vlan_id;
    } phv_t;

    typedef struct packed {
        logic         wr_en;
        logic [3:0]   index;
        table_entry_t entry;
    } table_wr_t;

endpackage

`default_nettype wire

/* design/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    typedef struct packed {
        logic [parser_pkg::DATA_WIDTH-1:0]   tdata;
        logic [parser_pkg::DATA_WIDTH/8-1:0] tkeep;
        logic                                tlast;
    } c_beat_t;

    // module id byte, low 3 bits hold the target parser
    localparam int MODID_LSB = 368;

    // udp destination port marking a table update
    localparam int          FLAG_LSB   = 320;
    localparam logic [15:0] FLAG_VALUE = 16'hf2f1;

    // starting table index, low 4 bits used
    localparam int INDEX_LSB = 384;

    typedef enum logic [1:0] {
        C_IDLE,
        C_FIRST,
        C_NEXT
    } cstate_e;

endpackage

`default_nettype wire

/* design/hdr_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module hdr_capture (
    input  wire                              axis_clk,
    input  wire                              aresetn,
    input  wire [parser_pkg::DATA_WIDTH-1:0] s_axis_tdata_i,
    input  wire                              s_axis_tvalid_i,
    input  wire                              s_axis_tlast_i,
    output logic                             pkt_start_o,
    output parser_pkg::hdr_t                 hdr_o,
    output logic [11:0]                      vlan_id_o
);
    import parser_pkg::*;

    logic tvalid_d;
    logic second_due;
    logic start;

    // packet starts on a rising tvalid
    assign start = s_axis_tvalid_i && !tvalid_d;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            tvalid_d    <= 1'b0;
            second_due  <= 1'b0;
            pkt_start_o <= 1'b0;
        end else begin
            tvalid_d    <= s_axis_tvalid_i;
            pkt_start_o <= start;
            second_due  <= start && !s_axis_tlast_i;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (start) begin
            hdr_o[DATA_WIDTH-1:0] <= s_axis_tdata_i;
            vlan_id_o             <= s_axis_tdata_i[VLAN_LSB +: 12];
            if (s_axis_tlast_i) begin
                hdr_o[HDR_BYTES*8-1:DATA_WIDTH] <= '0;
            end
        end else if (second_due && s_axis_tvalid_i) begin
            hdr_o[HDR_BYTES*8-1:DATA_WIDTH] <= s_axis_tdata_i;
        end
    end

endmodule

`default_nettype wire

/* design/action_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module action_ram (
    input  wire                          axis_clk,
    input  wire                          aresetn,
    input  wire parser_pkg::table_wr_t   wr_i,
    input  wire [3:0]                    rd_index_i,
    output parser_pkg::table_entry_t     entry_o
);
    import parser_pkg::*;

    table_entry_t mem [TABLE_DEPTH];

    // empty entries decode as CT_NONE everywhere
    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                mem[i] <= '0;
            end
            entry_o <= '0;
        end else begin
            if (wr_i.wr_en) begin
                mem[wr_i.index] <= wr_i.entry;
            end
            entry_o <= mem[rd_index_i];
        end
    end

    assert property (@(posedge axis_clk) disable iff (!aresetn) !$isunknown(wr_i.wr_en));

endmodule

`default_nettype wire

/* design/field_extractor.sv */
`timescale 1ns/10ps
`default_nettype none

module field_extractor (
    input  wire                            axis_clk,
    input  wire                            aresetn,
    input  wire                            fire_i,
    input  wire parser_pkg::hdr_t          hdr_i,
    input  wire parser_pkg::parse_action_t action_i,
    output parser_pkg::field_t             field_o
);
    import parser_pkg::*;

    hdr_t        shifted;
    logic [47:0] mask;

    // first field byte lands lowest, bytes past the header shift in as zero
    assign shifted = hdr_i >> {action_i.offset, 3'b000};

    always_comb begin
        case (action_i.kind)
            CT_2B:   mask = 48'h0000_0000_ffff;
            CT_4B:   mask = 48'h0000_ffff_ffff;
            CT_6B:   mask = 48'hffff_ffff_ffff;
            default: mask = 48'h0;
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            field_o <= '0;
        end else if (fire_i) begin
            field_o.kind  <= action_i.kind;
            field_o.idx   <= action_i.idx;
            field_o.value <= shifted[47:0] & mask;
        end
    end

endmodule

`default_nettype wire

/* design/phv_builder.sv */
`timescale 1ns/10ps
`default_nettype none

module phv_builder (
    input  wire                                               axis_clk,
    input  wire                                               aresetn,
    input  wire                                               pkt_start_i,
    input  wire [11:0]                                        vlan_id_i,
    input  wire parser_pkg::field_t [parser_pkg::NUM_ACTIONS-1:0] fields_i,
    input  wire                                               m_axis_tready_i,
    output logic                                              fire_o,
    output logic                                              s_axis_tready_o,
    output logic                                              phv_valid_o,
    output parser_pkg::phv_t                                  phv_o
);
    import parser_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_FIRE,
        P_COLLECT,
        P_HALT
    } pstate_e;

    pstate_e          state;
    logic [7:0][47:0] c6_q;
    logic [7:0][31:0] c4_q;
    logic [7:0][15:0] c2_q;
    logic [11:0]      vlan_q;

    assign fire_o          = (state == P_FIRE);
    assign s_axis_tready_o = (state == P_IDLE) && !pkt_start_i;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= P_IDLE;
            phv_valid_o <= 1'b0;
            c6_q        <= '0;
            c4_q        <= '0;
            c2_q        <= '0;
            vlan_q      <= '0;
        end else begin
            phv_valid_o <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (pkt_start_i) begin
                        c6_q  <= '0;
                        c4_q  <= '0;
                        c2_q  <= '0;
                        state <= P_FIRE;
                    end
                end
                P_FIRE: begin
                    state <= P_COLLECT;
                end
                P_COLLECT: begin
                    // later actions override earlier ones on the same container
                    for (int i = 0; i < NUM_ACTIONS; i++) begin
                        case (fields_i[i].kind)
                            CT_2B:   c2_q[fields_i[i].idx] <= fields_i[i].value[15:0];
                            CT_4B:   c4_q[fields_i[i].idx] <= fields_i[i].value[31:0];
                            CT_6B:   c6_q[fields_i[i].idx] <= fields_i[i].value;
                            default: ;
                        endcase
                    end
                    vlan_q <= vlan_id_i;
                    if (m_axis_tready_i) begin
                        phv_valid_o <= 1'b1;
                        state       <= P_IDLE;
                    end else begin
                        state <= P_HALT;
                    end
                end
                P_HALT: begin
                    if (m_axis_tready_i) begin
                        phv_valid_o <= 1'b1;
                        state       <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // big endian output, first header byte on top
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            phv_o.c6[k] = {<<8{c6_q[k]}};
            phv_o.c4[k] = {<<8{c4_q[k]}};
            phv_o.c2[k] = {<<8{c2_q[k]}};
        end
        phv_o.vlan_id = vlan_q;
    end

    assert property (@(posedge axis_clk) disable iff (!aresetn) pkt_start_i |-> state == P_IDLE);
    assert property (@(posedge axis_clk) disable iff (!aresetn) phv_valid_o |=> !phv_valid_o);

endmodule

`default_nettype wire

/* design/ctrl_table_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrl_table_writer #(
    parameter int unsigned PARSER_ID = 0
) (
    input  wire                      axis_clk,
    input  wire                      aresetn,
    input  wire ctrl_pkg::c_beat_t   c_s_beat_i,
    input  wire                      c_s_valid_i,
    output ctrl_pkg::c_beat_t        c_m_beat_o,
    output logic                     c_m_valid_o,
    output parser_pkg::table_wr_t    wr_o
);
    import parser_pkg::*;
    import ctrl_pkg::*;

    cstate_e               c_state;
    logic                  hdr_match;
    logic [DATA_WIDTH-1:0] swapped;
    logic                  wr_en_q;
    logic [3:0]            wr_idx_q;
    table_entry_t          wr_entry_q;

    assign hdr_match = c_s_valid_i
                    && c_s_beat_i.tdata[MODID_LSB +: 3] == PARSER_ID[2:0]
                    && c_s_beat_i.tdata[FLAG_LSB +: 16] == FLAG_VALUE;

    // table data arrives little endian
    assign swapped = {<<8{c_s_beat_i.tdata}};

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            c_state     <= C_IDLE;
            c_m_valid_o <= 1'b0;
            wr_en_q     <= 1'b0;
            wr_idx_q    <= '0;
        end else begin
            c_m_valid_o <= 1'b0;
            wr_en_q     <= 1'b0;
            case (c_state)
                C_IDLE: begin
                    if (hdr_match) begin
                        wr_idx_q <= c_s_beat_i.tdata[INDEX_LSB +: 4];
                        if (!c_s_beat_i.tlast) begin
                            c_state <= C_FIRST;
                        end
                    end else begin
                        c_m_valid_o <= c_s_valid_i;
                    end
                end
                C_FIRST, C_NEXT: begin
                    if (c_s_valid_i) begin
                        wr_en_q <= 1'b1;
                        if (c_state == C_NEXT) begin
                            wr_idx_q <= wr_idx_q + 4'd1;
                        end
                        c_state <= c_s_beat_i.tlast ? C_IDLE : C_NEXT;
                    end
                end
                default: c_state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (c_state == C_IDLE && !hdr_match) begin
            c_m_beat_o <= c_s_beat_i;
        end
        if (c_state != C_IDLE && c_s_valid_i) begin
            wr_entry_q <= swapped[DATA_WIDTH-1 -: $bits(table_entry_t)];
        end
    end

    assign wr_o = '{wr_en: wr_en_q, index: wr_idx_q, entry: wr_entry_q};

    assert property (@(posedge axis_clk) disable iff (!aresetn)
        c_m_valid_o |-> c_state == C_IDLE && !wr_en_q);

endmodule

`default_nettype wire

/* design/parser_top.sv */
`timescale 1ns/10ps
`default_nettype none

module parser_top #(
    parameter int unsigned PARSER_ID = 0
) (
    input  wire                              axis_clk,
    input  wire                              aresetn,
    input  wire [parser_pkg::DATA_WIDTH-1:0] s_axis_tdata_i,
    input  wire                              s_axis_tvalid_i,
    input  wire                              s_axis_tlast_i,
    output logic                             s_axis_tready_o,
    output parser_pkg::phv_t                 phv_o,
    output logic                             phv_valid_o,
    input  wire                              m_axis_tready_i,
    input  wire ctrl_pkg::c_beat_t           c_s_beat_i,
    input  wire                              c_s_valid_i,
    output ctrl_pkg::c_beat_t                c_m_beat_o,
    output logic                             c_m_valid_o
);
    import parser_pkg::*;

    logic                          pkt_start;
    hdr_t                          hdr;
    logic [11:0]                   vlan_id;
    table_entry_t                  entry;
    table_wr_t                     table_wr;
    logic                          fire;
    field_t [NUM_ACTIONS-1:0]      fields;

    hdr_capture u_hdr_capture (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .pkt_start_o     (pkt_start),
        .hdr_o           (hdr),
        .vlan_id_o       (vlan_id)
    );

    // table lookup keyed by vlan id bits 7:4
    action_ram u_action_ram (
        .axis_clk   (axis_clk),
        .aresetn    (aresetn),
        .wr_i       (table_wr),
        .rd_index_i (vlan_id[7:4]),
        .entry_o    (entry)
    );

    for (genvar g = 0; g < NUM_ACTIONS; g++) begin : g_fx
        field_extractor u_field_extractor (
            .axis_clk (axis_clk),
            .aresetn  (aresetn),
            .fire_i   (fire),
            .hdr_i    (hdr),
            .action_i (entry[g]),
            .field_o  (fields[g])
        );
    end

    phv_builder u_phv_builder (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .pkt_start_i     (pkt_start),
        .vlan_id_i       (vlan_id),
        .fields_i        (fields),
        .m_axis_tready_i (m_axis_tready_i),
        .fire_o          (fire),
        .s_axis_tready_o (s_axis_tready_o),
        .phv_valid_o     (phv_valid_o),
        .phv_o           (phv_o)
    );

    ctrl_table_writer #(
        .PARSER_ID (PARSER_ID)
    ) u_ctrl_table_writer (
        .axis_clk    (axis_clk),
        .aresetn     (aresetn),
        .c_s_beat_i  (c_s_beat_i),
        .c_s_valid_i (c_s_valid_i),
        .c_m_beat_o  (c_m_beat_o),
        .c_m_valid_o (c_m_valid_o),
        .wr_o        (table_wr)
    );

endmodule

`default_nettype wire

/* bench/parser_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module parser_tb;
    import parser_pkg::*;
    import ctrl_pkg::*;

    localparam int unsigned PARSER_ID = 3;
    localparam int NUM_WR      = 24;
    localparam int NUM_PKTS    = 64;
    localparam int WATCHDOG_NS = (NUM_WR + NUM_WR / 2 + NUM_PKTS) * 200;

    logic                  axis_clk;
    logic                  aresetn;
    logic [DATA_WIDTH-1:0] s_axis_tdata_i;
    logic                  s_axis_tvalid_i;
    logic                  s_axis_tlast_i;
    logic                  s_axis_tready_o;
    phv_t                  phv_o;
    logic                  phv_valid_o;
    logic                  m_axis_tready_i;
    c_beat_t               c_s_beat_i;
    logic                  c_s_valid_i;
    c_beat_t               c_m_beat_o;
    logic                  c_m_valid_o;

    integer       seed;
    table_entry_t table_model [TABLE_DEPTH];
    logic         fwd_due;
    c_beat_t      fwd_beat;

    parser_top #(.PARSER_ID(PARSER_ID)) dut (.*);

    initial axis_clk = 1'b0;
    always #4 axis_clk = ~axis_clk;

    task automatic stop_with_error(string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_phv(phv_t got, phv_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %0t: phv mismatch\n  got %h\n  exp %h",
                                      $time, got, exp));
        end
    endtask

    task automatic check_beat(c_beat_t got, c_beat_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %0t: forwarded beat mismatch\n  got %h\n  exp %h",
                                      $time, got, exp));
        end
    endtask

    // one clock, then check the forward expected from the beat just sampled
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
        check_bit(c_m_valid_o, fwd_due, "c_m_valid_o");
        if (fwd_due) begin
            check_beat(c_m_beat_o, fwd_beat);
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] rand_data();
        logic [DATA_WIDTH-1:0] d;
        for (int w = 0; w < DATA_WIDTH / 32; w++) begin
            d[32*w +: 32] = $random(seed);
        end
        return d;
    endfunction

    function automatic c_beat_t rand_beat(logic last);
        c_beat_t b;
        b.tdata = rand_data();
        b.tkeep = {$random(seed), $random(seed)};
        b.tlast = last;
        return b;
    endfunction

    // offsets near the header end now and then
    function automatic parse_action_t rand_action();
        parse_action_t a;
        a = 16'($random(seed));
        if (($random(seed) & 3) == 0) begin
            a.offset = 7'(120 + ($random(seed) & 7));
        end
        return a;
    endfunction

    // table data travels little endian, action 0 in byte 0
    function automatic c_beat_t entry_beat(table_entry_t e, logic last);
        c_beat_t      b;
        logic [159:0] bits;
        bits = e;
        b    = rand_beat(last);
        for (int j = 0; j < 20; j++) begin
            b.tdata[8*j +: 8] = bits[8*(19-j) +: 8];
        end
        return b;
    endfunction

    function automatic phv_t predict_phv(hdr_t hdr);
        phv_t          p;
        parse_action_t a;
        logic [47:0]   v;
        int            n;
        int            pos;
        p         = '0;
        p.vlan_id = hdr[VLAN_LSB +: 12];
        for (int i = 0; i < NUM_ACTIONS; i++) begin
            a = table_model[p.vlan_id[7:4]][i];
            n = (a.kind == CT_2B) ? 2 : (a.kind == CT_4B) ? 4 : (a.kind == CT_6B) ? 6 : 0;
            v = '0;
            for (int j = 0; j < n; j++) begin
                pos = int'(a.offset) + j;
                v   = {v[39:0], (pos < HDR_BYTES) ? hdr[8*pos +: 8] : 8'h00};
            end
            case (a.kind)
                CT_2B:   p.c2[a.idx] = v[15:0];
                CT_4B:   p.c4[a.idx] = v[31:0];
                CT_6B:   p.c6[a.idx] = v;
                default: ;
            endcase
        end
        return p;
    endfunction

    task automatic drive_ctrl(c_beat_t beat, logic valid, logic fwd);
        c_s_beat_i  = beat;
        c_s_valid_i = valid;
        fwd_due     = fwd;
        fwd_beat    = beat;
        next_cycle();
    endtask

    task automatic send_write_frame();
        c_beat_t      b;
        table_entry_t e;
        int           nb;
        logic [3:0]   idx;
        nb  = 1 + $unsigned($random(seed)) % 4;
        idx = 4'($random(seed));
        b   = rand_beat(1'b0);
        b.tdata[MODID_LSB +: 3] = PARSER_ID[2:0];
        b.tdata[FLAG_LSB +: 16] = FLAG_VALUE;
        b.tdata[INDEX_LSB +: 4] = idx;
        drive_ctrl(b, 1'b1, 1'b0);
        for (int k = 0; k < nb; k++) begin
            for (int a = 0; a < NUM_ACTIONS; a++) begin
                e[a] = rand_action();
            end
            while (($random(seed) & 3) == 0) begin
                drive_ctrl(rand_beat(1'b0), 1'b0, 1'b0);
            end
            drive_ctrl(entry_beat(e, k == nb - 1), 1'b1, 1'b0);
            table_model[idx] = e;
            idx = idx + 4'd1;
        end
    endtask

    // every beat misses either the module id or the flag
    task automatic send_pass_frame();
        c_beat_t b;
        int      nb;
        nb = 1 + $unsigned($random(seed)) % 3;
        for (int k = 0; k < nb; k++) begin
            b = rand_beat(k == nb - 1);
            b.tdata[FLAG_LSB +: 16] = FLAG_VALUE;
            if ($random(seed) & 1) begin
                b.tdata[MODID_LSB +: 3] =
                    PARSER_ID[2:0] ^ 3'(1 << ($unsigned($random(seed)) % 3));
            end else begin
                b.tdata[FLAG_LSB +: 16] = FLAG_VALUE ^ 16'(1 << ($unsigned($random(seed)) % 16));
            end
            if (($random(seed) & 3) == 0) begin
                drive_ctrl(rand_beat(1'b0), 1'b0, 1'b0);
            end
            drive_ctrl(b, 1'b1, 1'b1);
        end
    endtask

    task automatic send_packet(logic [3:0] nib, logic bp);
        hdr_t hdr;
        phv_t exp;
        logic two;
        logic rdy;
        logic done;
        int   edges;
        hdr = {rand_data(), rand_data()};
        hdr[VLAN_LSB + 4 +: 4] = nib;
        two = 1'($random(seed));
        if (!two) begin
            hdr[HDR_BYTES*8-1:DATA_WIDTH] = '0;
        end
        exp = predict_phv(hdr);
        while (s_axis_tready_o !== 1'b1) begin
            next_cycle();
        end
        s_axis_tvalid_i = 1'b1;
        s_axis_tdata_i  = hdr[DATA_WIDTH-1:0];
        s_axis_tlast_i  = !two;
        m_axis_tready_i = bp ? 1'($random(seed)) : 1'b1;
        next_cycle();
        check_bit(s_axis_tready_o, 1'b0, "s_axis_tready_o after start");
        check_bit(phv_valid_o, 1'b0, "phv_valid_o after start");
        edges = 0;
        done  = 1'b0;
        while (!done) begin
            if (edges == 0 && two) begin
                s_axis_tdata_i = hdr[HDR_BYTES*8-1:DATA_WIDTH];
                s_axis_tlast_i = 1'b1;
            end else begin
                s_axis_tvalid_i = 1'b0;
                s_axis_tlast_i  = 1'b0;
                s_axis_tdata_i  = rand_data();
            end
            rdy = bp ? 1'($random(seed)) : 1'b1;
            m_axis_tready_i = rdy;
            next_cycle();
            edges++;
            // pulse on the first ready edge from the third edge on
            done = (edges >= 3) && rdy;
            check_bit(phv_valid_o, done, "phv_valid_o");
            check_bit(s_axis_tready_o, done, "s_axis_tready_o");
        end
        check_phv(phv_o, exp);
    endtask

    initial begin
        seed            = 32'ha108;
        aresetn         = 1'b0;
        s_axis_tdata_i  = '0;
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        m_axis_tready_i = 1'b1;
        c_s_beat_i      = '0;
        c_s_valid_i     = 1'b0;
        fwd_due         = 1'b0;
        fwd_beat        = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            table_model[i] = '0;
        end
        repeat (4) @(posedge axis_clk);
        #1;
        aresetn = 1'b1;
        check_bit(s_axis_tready_o, 1'b1, "s_axis_tready_o after reset");
        check_bit(phv_valid_o, 1'b0, "phv_valid_o after reset");
        check_bit(c_m_valid_o, 1'b0, "c_m_valid_o after reset");

        for (int f = 0; f < 16; f++) begin
            send_write_frame();
            if (f % 2 == 1) begin
                send_pass_frame();
            end
        end
        // let the last table write land
        repeat (2) drive_ctrl(rand_beat(1'b0), 1'b0, 1'b0);
        for (int p = 0; p < NUM_PKTS / 2; p++) begin
            send_packet(4'(p), 1'b0);
        end

        for (int f = 16; f < NUM_WR; f++) begin
            send_write_frame();
            if (f % 2 == 1) begin
                send_pass_frame();
            end
        end
        repeat (2) drive_ctrl(rand_beat(1'b0), 1'b0, 1'b0);
        for (int p = 0; p < NUM_PKTS / 2; p++) begin
            send_packet(4'($random(seed)), 1'b1);
        end

        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_error($sformatf("timeout: the test did not finish within %0d ns", WATCHDOG_NS));
    end

endmodule

`default_nettype wire

/* files.f */
design/parser_pkg.sv
design/ctrl_pkg.sv
design/hdr_capture.sv
design/action_ram.sv
design/field_extractor.sv
design/phv_builder.sv
design/ctrl_table_writer.sv
design/parser_top.sv
bench/parser_tb.sv

/* Bender.yml */
package:
  name: packet_parser

sources:
  - design/parser_pkg.sv
  - design/ctrl_pkg.sv
  - design/hdr_capture.sv
  - design/action_ram.sv
  - design/field_extractor.sv
  - design/phv_builder.sv
  - design/ctrl_table_writer.sv
  - design/parser_top.sv
  - target: test
    files:
      - bench/parser_tb.sv
